// File: compile.f
+incdir+tests
hdl/vlsu_pkg.sv
hdl/circ_queue_ptr.sv
hdl/shf_info_queue.sv
hdl/deshuffle_unit.sv
hdl/vrf_seq_store.sv
hdl/vlsu_load_path.sv
tests/tb_vlsu_load_path.sv

// File: run_verilator.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_vlsu_load_path -f compile.f
out=$(./obj_dir/Vtb_vlsu_load_path)
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: tests/tb_ref_model.svh
// Reference model of the load-return path, included inside the testbench module
// Expects NrRows to be declared before the include
// SEW32 elements reach the lanes as lane-wide halves, placed like SEW16 units
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Random source, x^16 + x^14 + x^13 + x^11 + 1
logic [15:0] lfsr_q = 16'd86;

// Expected register-file image, zero like the DUT after reset
logic [vlsu_pkg::RowBits-1:0] shadow_q [NrRows] = '{default: '0};

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per returned bit
function automatic logic [63:0] rand_bits(input int unsigned n);
  logic [63:0] v;
  v = '0;
  for (int unsigned i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    v      = {v[62:0], lfsr_q[15]};
  end
  return v;
endfunction

// Sequential nibble index held at a lane offset
function automatic int unsigned seq_of(input int unsigned lane, input int unsigned off,
                                       input vlsu_pkg::sew_e sew);
  int unsigned unit_nb;
  int unsigned elem;
  unit_nb = 32'd2 << sew;
  // Wider elements split at the lane width
  if (unit_nb > vlsu_pkg::NbPerLane) begin
    unit_nb = vlsu_pkg::NbPerLane;
  end
  elem = (off / unit_nb) * vlsu_pkg::NrLanes + lane;
  return elem * unit_nb + off % unit_nb;
endfunction

// Sequential row to the four lane words, lane l in bits [16l +: 16]
function automatic logic [vlsu_pkg::RowBits-1:0] shuffle_row(
  input logic [vlsu_pkg::RowBits-1:0] row, input vlsu_pkg::sew_e sew);
  logic [vlsu_pkg::RowBits-1:0] words;
  int unsigned                  s;
  words = '0;
  for (int unsigned l = 0; l < vlsu_pkg::NrLanes; l++) begin
    for (int unsigned o = 0; o < vlsu_pkg::NbPerLane; o++) begin
      s = seq_of(l, o, sew);
      words[(l * vlsu_pkg::NbPerLane + o) * 4 +: 4] = row[s * 4 +: 4];
    end
  end
  return words;
endfunction

// Write enable per sequential nibble, taken from the mask bit of its source
function automatic logic [vlsu_pkg::NbPerRow-1:0] row_enables(
  input vlsu_pkg::mask_t m, input logic vm, input vlsu_pkg::sew_e sew);
  logic [vlsu_pkg::NbPerRow-1:0] en;
  en = '0;
  for (int unsigned l = 0; l < vlsu_pkg::NrLanes; l++) begin
    for (int unsigned o = 0; o < vlsu_pkg::NbPerLane; o++) begin
      en[seq_of(l, o, sew)] = vm | m[l][o];
    end
  end
  return en;
endfunction

// Disabled nibbles keep the old image value
function automatic void shadow_write(input int unsigned addr,
                                     input logic [vlsu_pkg::RowBits-1:0] row,
                                     input logic [vlsu_pkg::NbPerRow-1:0] en);
  for (int unsigned s = 0; s < vlsu_pkg::NbPerRow; s++) begin
    if (en[s]) begin
      shadow_q[addr][s * 4 +: 4] = row[s * 4 +: 4];
    end
  end
endfunction

`endif

// File: tests/tb_vlsu_load_path.sv
// Testbench of the load-return path, inputs driven 1 ns after each rising edge
// Meta of a request always goes out before its lane words
// Rows are checked through the read port against the reference image
`timescale 1ns/1ps

module tb_vlsu_load_path;

  localparam int unsigned InfoDepth     = 4;
  localparam int unsigned NrRows        = 16;
  localparam int unsigned RdAddrW       = $clog2(NrRows);
  // Rows sent over all tests, sizes the watchdog
  localparam int unsigned RowsSent      = 17;
  localparam int unsigned TimeoutCycles = 40 * RowsSent + 200;

  `include "tb_ref_model.svh"

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                 [vlsu_pkg::NrLanes-1:0] rx_valid_i;
  logic                 [vlsu_pkg::NrLanes-1:0] rx_ready_o;
  vlsu_pkg::lane_data_t [vlsu_pkg::NrLanes-1:0] rx_i;
  logic                                        meta_valid_i;
  logic                                        meta_ready_o;
  vlsu_pkg::meta_t                             meta_i;
  logic                                        mask_valid_i;
  vlsu_pkg::mask_t                             mask_i;
  logic                                        mask_ready_o;
  logic                                        rd_en_i;
  logic                 [RdAddrW-1:0]          rd_addr_i;
  logic                 [vlsu_pkg::RowBits-1:0] rd_data_o;
  logic                                        rd_valid_o;

  string       cur_test       = "reset";
  int unsigned err_cnt        = 0;
  int unsigned test_err_start = 0;
  int unsigned tests_run      = 0;
  int unsigned tests_failed   = 0;
  int unsigned held_reads     = 0;
  logic        beats_done     = 1'b0;
  logic        rd_en_q        = 1'b0;

  vlsu_load_path #(
    .InfoDepth (InfoDepth),
    .NrRows    (NrRows)
  ) i_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_valid_i   (rx_valid_i),
    .rx_ready_o   (rx_ready_o),
    .rx_i         (rx_i),
    .meta_valid_i (meta_valid_i),
    .meta_ready_o (meta_ready_o),
    .meta_i       (meta_i),
    .mask_valid_i (mask_valid_i),
    .mask_i       (mask_i),
    .mask_ready_o (mask_ready_o),
    .rd_en_i      (rd_en_i),
    .rd_addr_i    (rd_addr_i),
    .rd_data_o    (rd_data_o),
    .rd_valid_o   (rd_valid_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Drive helpers, all start and end 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  function automatic vlsu_pkg::meta_t make_meta(input int unsigned id,
    input vlsu_pkg::sew_e sew, input int unsigned vd, input int unsigned start_row,
    input logic vm, input int unsigned rows);
    vlsu_pkg::meta_t m;
    m.req_id    = 4'(id);
    m.sew       = sew;
    m.vd        = 3'(vd);
    m.start_row = start_row[0];
    m.vm        = vm;
    m.cmt_cnt   = 3'(rows - 1);
    return m;
  endfunction

  task automatic send_meta(input vlsu_pkg::meta_t m);
    meta_valid_i = 1'b1;
    meta_i       = m;
    @(negedge clk_i);
    while (!meta_ready_o) begin
      @(negedge clk_i);
    end
    tick();
    meta_valid_i = 1'b0;
  endtask

  // Lane l goes valid after l*stagger cycles; the mask is held until consumed
  task automatic send_beat(input logic [vlsu_pkg::RowBits-1:0] words, input logic masked,
                           input vlsu_pkg::mask_t m, input int unsigned stagger);
    logic [vlsu_pkg::NrLanes-1:0] done;
    logic [vlsu_pkg::NrLanes-1:0] take;
    int unsigned                  cyc;
    done = '0;
    cyc  = 0;
    if (masked) begin
      mask_valid_i = 1'b1;
      mask_i       = m;
    end
    while (done != '1) begin
      for (int unsigned l = 0; l < vlsu_pkg::NrLanes; l++) begin
        if (!done[l] && cyc >= l * stagger) begin
          rx_valid_i[l] = 1'b1;
          rx_i[l]       = words[l * vlsu_pkg::DLEN +: vlsu_pkg::DLEN];
        end
      end
      @(negedge clk_i);
      take = rx_valid_i & rx_ready_o;
      tick();
      done       = done | take;
      rx_valid_i = rx_valid_i & ~take;
      cyc++;
    end
    if (masked) begin
      @(negedge clk_i);
      while (!mask_ready_o) begin
        @(negedge clk_i);
      end
      tick();
      mask_valid_i = 1'b0;
    end
  endtask

  // Random row, image updated first, then the shuffled beat goes out
  task automatic load_row(input int unsigned addr, input vlsu_pkg::sew_e sew,
                          input logic vm, input int unsigned stagger);
    logic [vlsu_pkg::RowBits-1:0] row;
    logic [63:0]                  bits;
    vlsu_pkg::mask_t              m;
    row  = rand_bits(64);
    bits = rand_bits(16);
    m    = vm ? '0 : bits[15:0];
    shadow_write(addr, row, row_enables(m, vm, sew));
    send_beat(shuffle_row(row, sew), !vm, m, stagger);
  endtask

  // Slots empty again means the last beat has committed
  task automatic wait_idle();
    @(negedge clk_i);
    while (rx_ready_o != '1) begin
      @(negedge clk_i);
    end
    tick();
  endtask

  task automatic check_row(input int unsigned addr);
    rd_en_i   = 1'b1;
    rd_addr_i = RdAddrW'(addr);
    tick();
    rd_en_i = 1'b0;
    assert (rd_data_o === shadow_q[addr]) else begin
      $display("ERROR %s: row %0d expected %h actual %h", cur_test, addr, shadow_q[addr],
               rd_data_o);
      err_cnt++;
    end
  endtask

  // Reads on every other cycle in which a full beat waits to commit
  task automatic pressure_reads();
    logic        prev_rd;
    int unsigned prev_addr;
    int unsigned addr;
    prev_rd   = 1'b0;
    prev_addr = 0;
    addr      = 2;
    while (!beats_done) begin
      if (prev_rd) begin
        assert (rd_data_o === shadow_q[prev_addr]) else begin
          $display("ERROR %s: row %0d expected %h actual %h", cur_test, prev_addr,
                   shadow_q[prev_addr], rd_data_o);
          err_cnt++;
        end
      end
      if (rx_ready_o == '0 && !prev_rd) begin
        rd_en_i   = 1'b1;
        rd_addr_i = RdAddrW'(addr);
        prev_addr = addr;
        addr      = (addr == 4) ? 2 : addr + 1;
        held_reads++;
      end else begin
        rd_en_i = 1'b0;
      end
      prev_rd = rd_en_i;
      tick();
    end
    rd_en_i = 1'b0;
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt == test_err_start) begin
      $display("%s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed, %0d errors", cur_test, err_cnt - test_err_start);
    end
  endtask

  // rd_valid_o must follow rd_en_i by exactly one cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      assert (rd_valid_o == rd_en_q) else begin
        $display("ERROR %s: rd_valid_o expected %0b actual %0b", cur_test, rd_en_q, rd_valid_o);
        err_cnt++;
      end
    end
    rd_en_q = rd_en_i;
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk_i);
    $display("Watchdog: run did not complete within %0d cycles", TimeoutCycles);
    $display("Test FAILED");
    $finish;
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    rst_ni       = 1'b0;
    rx_valid_i   = '0;
    rx_i         = '0;
    meta_valid_i = 1'b0;
    meta_i       = '0;
    mask_valid_i = 1'b0;
    mask_i       = '0;
    rd_en_i      = 1'b0;
    rd_addr_i    = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test("reset");
    assert (rx_ready_o == '1 && meta_ready_o && !mask_ready_o && !rd_valid_o) else begin
      $display("Handshake outputs not at their reset values after reset");
      err_cnt++;
    end
    check_row(0);
    check_row(NrRows - 1);
    end_test();

    // One unmasked row per element width
    begin_test("unmasked_widths");
    send_meta(make_meta(1, vlsu_pkg::SEW8, 1, 0, 1'b1, 1));
    load_row(2, vlsu_pkg::SEW8, 1'b1, 0);
    send_meta(make_meta(2, vlsu_pkg::SEW16, 1, 1, 1'b1, 1));
    load_row(3, vlsu_pkg::SEW16, 1'b1, 0);
    send_meta(make_meta(3, vlsu_pkg::SEW32, 2, 0, 1'b1, 1));
    load_row(4, vlsu_pkg::SEW32, 1'b1, 0);
    wait_idle();
    check_row(2);
    check_row(3);
    check_row(4);
    end_test();

    // Four rows from 7, then the next request at its own base 12
    begin_test("multi_row");
    send_meta(make_meta(4, vlsu_pkg::SEW16, 3, 1, 1'b1, 4));
    send_meta(make_meta(5, vlsu_pkg::SEW8, 6, 0, 1'b1, 1));
    for (int unsigned r = 7; r <= 10; r++) begin
      load_row(r, vlsu_pkg::SEW16, 1'b1, 0);
    end
    load_row(12, vlsu_pkg::SEW8, 1'b1, 0);
    wait_idle();
    for (int unsigned r = 7; r <= 12; r++) begin
      check_row(r);
    end
    end_test();

    // Overwrite earlier rows under random masks
    begin_test("masked");
    send_meta(make_meta(6, vlsu_pkg::SEW8, 1, 0, 1'b0, 2));
    send_meta(make_meta(7, vlsu_pkg::SEW32, 2, 0, 1'b0, 1));
    load_row(2, vlsu_pkg::SEW8, 1'b0, 0);
    load_row(3, vlsu_pkg::SEW8, 1'b0, 0);
    load_row(4, vlsu_pkg::SEW32, 1'b0, 0);
    wait_idle();
    check_row(2);
    check_row(3);
    check_row(4);
    end_test();

    // Lanes arrive apart while reads hold the commit
    begin_test("staggered_backpressure");
    beats_done = 1'b0;
    held_reads = 0;
    fork
      begin
        send_meta(make_meta(8, vlsu_pkg::SEW16, 0, 0, 1'b0, 2));
        load_row(0, vlsu_pkg::SEW16, 1'b0, 3);
        load_row(1, vlsu_pkg::SEW16, 1'b0, 2);
        wait_idle();
        beats_done = 1'b1;
      end
      pressure_reads();
    join
    assert (held_reads > 0) else begin
      $display("No read was issued while a complete beat waited to commit");
      err_cnt++;
    end
    check_row(0);
    check_row(1);
    end_test();

    // Fill the request queue before any lane data
    begin_test("queued_requests");
    send_meta(make_meta(9, vlsu_pkg::SEW8, 4, 0, 1'b1, 1));
    send_meta(make_meta(10, vlsu_pkg::SEW32, 5, 1, 1'b0, 1));
    send_meta(make_meta(11, vlsu_pkg::SEW16, 7, 0, 1'b1, 1));
    send_meta(make_meta(12, vlsu_pkg::SEW8, 0, 1, 1'b0, 1));
    @(negedge clk_i);
    assert (!meta_ready_o) else begin
      $display("meta_ready_o stayed high with a full request queue");
      err_cnt++;
    end
    tick();
    load_row(8, vlsu_pkg::SEW8, 1'b1, 0);
    load_row(11, vlsu_pkg::SEW32, 1'b0, 0);
    load_row(14, vlsu_pkg::SEW16, 1'b1, 0);
    load_row(1, vlsu_pkg::SEW8, 1'b0, 0);
    wait_idle();
    check_row(8);
    check_row(11);
    check_row(14);
    check_row(1);
    end_test();

    $display("tests run: %0d, tests failed: %0d, checks failed: %0d", tests_run,
             tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/vlsu_load_path.sv
// Load-return path of the vector load/store unit
// Request queue, de-shuffle unit and register file, all valid/ready
// Send each request's meta before its lane words
`timescale 1ns/1ps

module vlsu_load_path #(
  parameter int unsigned InfoDepth = 4,
  parameter int unsigned NrRows    = 16
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Lane exits
  input  logic                 [vlsu_pkg::NrLanes-1:0] rx_valid_i,
  output logic                 [vlsu_pkg::NrLanes-1:0] rx_ready_o,
  input  vlsu_pkg::lane_data_t [vlsu_pkg::NrLanes-1:0] rx_i,
  // Request meta
  input  logic                                        meta_valid_i,
  output logic                                        meta_ready_o,
  input  vlsu_pkg::meta_t                             meta_i,
  // Mask
  input  logic                                        mask_valid_i,
  input  vlsu_pkg::mask_t                             mask_i,
  output logic                                        mask_ready_o,
  // Read-back
  input  logic                                        rd_en_i,
  input  logic [((NrRows > 1) ? $clog2(NrRows) : 1)-1:0] rd_addr_i,
  output logic                 [vlsu_pkg::RowBits-1:0] rd_data_o,
  output logic                                        rd_valid_o
);

  logic                info_valid;
  vlsu_pkg::shf_info_t info;
  logic                commit;
  logic                row_valid;
  logic                row_ready;
  vlsu_pkg::seq_row_t  row;

  shf_info_queue #(
    .Depth (InfoDepth)
  ) i_shf_info_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_valid_i (meta_valid_i),
    .meta_ready_o (meta_ready_o),
    .meta_i       (meta_i),
    .info_valid_o (info_valid),
    .info_o       (info),
    .commit_i     (commit)
  );

  deshuffle_unit i_deshuffle_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_valid_i   (rx_valid_i),
    .rx_ready_o   (rx_ready_o),
    .rx_i         (rx_i),
    .info_valid_i (info_valid),
    .info_i       (info),
    .mask_valid_i (mask_valid_i),
    .mask_i       (mask_i),
    .mask_ready_o (mask_ready_o),
    .commit_o     (commit),
    .row_valid_o  (row_valid),
    .row_ready_i  (row_ready),
    .row_o        (row)
  );

  vrf_seq_store #(
    .NrRows (NrRows)
  ) i_vrf_seq_store (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .row_valid_i (row_valid),
    .row_ready_o (row_ready),
    .row_i       (row),
    .rd_en_i     (rd_en_i),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o),
    .rd_valid_o  (rd_valid_o)
  );

endmodule

// File: hdl/vrf_seq_store.sv
// Single-port vector register file, one row of NbPerRow nibbles per address
// Reads win over writes, a held write retries on the next free cycle
// Row index uses the low bits of row_addr, so NrRows must not exceed 32
`timescale 1ns/1ps

module vrf_seq_store #(
  parameter int unsigned  NrRows = 16,
  localparam int unsigned RowIdxW = (NrRows > 1) ? $clog2(NrRows) : 1
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Write side from the de-shuffle unit
  input  logic                           row_valid_i,
  output logic                           row_ready_o,
  input  vlsu_pkg::seq_row_t             row_i,
  // Read port
  input  logic                           rd_en_i,
  input  logic [RowIdxW-1:0]             rd_addr_i,
  output logic [vlsu_pkg::RowBits-1:0]   rd_data_o,
  output logic                           rd_valid_o
);

  logic [vlsu_pkg::NbPerRow-1:0][3:0] mem [NrRows];
  logic                               wr_en;
  logic [RowIdxW-1:0]                 wr_idx;

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------
  // Any read this cycle takes the single port
  assign row_ready_o = !rd_en_i;
  assign wr_en       = row_valid_i && row_ready_o;
  assign wr_idx      = row_i.row_addr[RowIdxW-1:0];

  // Contents come up as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < NrRows; r++) begin
        mem[r] <= '0;
      end
    end else if (wr_en) begin
      // Disabled nibbles keep their old value
      for (int unsigned n = 0; n < vlsu_pkg::NbPerRow; n++) begin
        if (row_i.en[n]) begin
          mem[wr_idx][n] <= row_i.nb[n];
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= rd_en_i;
    end
  end

  // Data one cycle after the request
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

  // A row held back by a read stays offered, nothing is dropped
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (row_valid_i && rd_en_i) |=> row_valid_i)
    else $error("vrf_seq_store: row withdrawn while held by a read");

endmodule

// File: hdl/deshuffle_unit.sv
// De-shuffle stage between the lane exits and the register file
// One slot per lane, a beat is complete once every slot holds a word
// Mask is sampled only when a masked request commits
`timescale 1ns/1ps

module deshuffle_unit (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Lane exits
  input  logic                 [vlsu_pkg::NrLanes-1:0] rx_valid_i,
  output logic                 [vlsu_pkg::NrLanes-1:0] rx_ready_o,
  input  vlsu_pkg::lane_data_t [vlsu_pkg::NrLanes-1:0] rx_i,
  // Head of the request queue
  input  logic                                        info_valid_i,
  input  vlsu_pkg::shf_info_t                         info_i,
  // Mask unit
  input  logic                                        mask_valid_i,
  input  vlsu_pkg::mask_t                             mask_i,
  output logic                                        mask_ready_o,
  // Commit pulse back to the queue
  output logic                                        commit_o,
  // Sequential row to the register file
  output logic                                        row_valid_o,
  input  logic                                        row_ready_i,
  output vlsu_pkg::seq_row_t                          row_o
);

  logic                 [vlsu_pkg::NrLanes-1:0] slot_valid;
  vlsu_pkg::lane_data_t [vlsu_pkg::NrLanes-1:0] slot_data;
  logic                                        slots_full;

  // ----------------------------------------------------------
  // Lane slots
  // ----------------------------------------------------------
  // Lane is ready only while its slot is empty
  assign rx_ready_o = ~slot_valid;
  assign slots_full = &slot_valid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid <= '0;
    end else if (commit_o) begin
      // All slots full here, so no lane can be accepted this cycle
      slot_valid <= '0;
    end else begin
      for (int unsigned l = 0; l < vlsu_pkg::NrLanes; l++) begin
        if (rx_valid_i[l] && rx_ready_o[l]) begin
          slot_valid[l] <= 1'b1;
        end
      end
    end
  end

  // Slot payload
  always_ff @(posedge clk_i) begin
    for (int unsigned l = 0; l < vlsu_pkg::NrLanes; l++) begin
      if (rx_valid_i[l] && rx_ready_o[l]) begin
        slot_data[l] <= rx_i[l];
      end
    end
  end

  // ----------------------------------------------------------
  // Commit control
  // ----------------------------------------------------------
  // Unmasked requests need no mask beat
  assign row_valid_o  = slots_full && info_valid_i && (info_i.vm || mask_valid_i);
  assign commit_o     = row_valid_o && row_ready_i;
  assign mask_ready_o = commit_o && !info_i.vm;

  // ----------------------------------------------------------
  // Nibble reorder
  // ----------------------------------------------------------
  always_comb begin
    vlsu_pkg::shf_pos_t pos;
    for (int unsigned s = 0; s < vlsu_pkg::NbPerRow; s++) begin
      pos = vlsu_pkg::shf_idx(s, info_i.sew);
      // Pick the source nibble out of its lane word
      row_o.nb[s] = slot_data[pos.lane].data[pos.off*4 +: 4];
      // Enable follows the mask bit of that same source nibble
      row_o.en[s] = info_i.vm || mask_i[pos.lane][pos.off];
    end
    row_o.row_addr = info_i.row_addr;
  end

  // Lane data for a row only arrives after its request was queued
  assert property (@(posedge clk_i) disable iff (!rst_ni) slots_full |-> info_valid_i)
    else $error("deshuffle_unit: complete beat without a pending request");

endmodule

// File: hdl/shf_info_queue.sv
// Request queue of the load-return path
// Head entry is updated in place per committed row and pops after its last row
// Request id is not tracked beyond this point
`timescale 1ns/1ps

module shf_info_queue #(
  parameter int unsigned Depth = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                meta_valid_i,
  output logic                meta_ready_o,
  input  vlsu_pkg::meta_t     meta_i,
  output logic                info_valid_o,
  output vlsu_pkg::shf_info_t info_o,
  input  logic                commit_i
);

  localparam int unsigned IdxW = (Depth > 1) ? $clog2(Depth) : 1;

  vlsu_pkg::shf_info_t q_mem [Depth];
  vlsu_pkg::shf_info_t enq_entry;
  vlsu_pkg::shf_info_t head;
  logic [IdxW-1:0]     enq_idx;
  logic [IdxW-1:0]     deq_idx;
  logic                enq_flag;
  logic                deq_flag;
  logic                empty;
  logic                full;
  logic                enq;
  logic                deq;
  logic                last_row;

  // ----------------------------------------------------------
  // Pointers
  // ----------------------------------------------------------
  circ_queue_ptr #(
    .Entries (Depth)
  ) i_enq_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (enq),
    .value_o (enq_idx),
    .flag_o  (enq_flag)
  );

  circ_queue_ptr #(
    .Entries (Depth)
  ) i_deq_ptr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .inc_i   (deq),
    .value_o (deq_idx),
    .flag_o  (deq_flag)
  );

  assign empty = (enq_idx == deq_idx) && (enq_flag == deq_flag);
  assign full  = (enq_idx == deq_idx) && (enq_flag != deq_flag);

  assign meta_ready_o = !full;
  assign enq          = meta_valid_i && meta_ready_o;

  // First row of the request inside the register file
  always_comb begin
    enq_entry.sew      = meta_i.sew;
    enq_entry.vm       = meta_i.vm;
    enq_entry.cmt_cnt  = meta_i.cmt_cnt;
    enq_entry.row_addr = vlsu_pkg::RowAddrW'(meta_i.vd) *
                         vlsu_pkg::RowAddrW'(vlsu_pkg::RowsPerVreg) +
                         vlsu_pkg::RowAddrW'(meta_i.start_row);
  end

  // ----------------------------------------------------------
  // Head and commit handling
  // ----------------------------------------------------------
  assign head         = q_mem[deq_idx];
  assign info_o       = head;
  assign info_valid_o = !empty;
  assign last_row     = (head.cmt_cnt == 3'd0);
  assign deq          = commit_i && last_row;

  // Enqueue slot and head never alias while both are active
  always_ff @(posedge clk_i) begin
    if (enq) begin
      q_mem[enq_idx] <= enq_entry;
    end
    if (commit_i && !last_row) begin
      q_mem[deq_idx].cmt_cnt  <= head.cmt_cnt - 3'd1;
      q_mem[deq_idx].row_addr <= head.row_addr + 1'b1;
    end
  end

  // De-shuffle side must only commit against a pending request
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_i |-> !empty)
    else $error("shf_info_queue: commit with empty request queue");

endmodule

// File: hdl/circ_queue_ptr.sv
// Wrapping queue pointer with a lap flag
// Works for any depth, not only powers of two
`timescale 1ns/1ps

module circ_queue_ptr #(
  parameter int unsigned  Entries = 4,
  localparam int unsigned IdxW    = (Entries > 1) ? $clog2(Entries) : 1
) (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            inc_i,
  output logic [IdxW-1:0] value_o,
  output logic            flag_o
);

  // Flag flips on every wrap, equal values then tell full from empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      value_o <= '0;
      flag_o  <= 1'b0;
    end else if (inc_i) begin
      if (value_o == IdxW'(Entries - 1)) begin
        value_o <= '0;
        flag_o  <= ~flag_o;
      end else begin
        value_o <= value_o + 1'b1;
      end
    end
  end

endmodule

// File: hdl/vlsu_pkg.sv
// Shared geometry and types of the vector load-return path
// Lane count and lane width are fixed here and size every packed struct
// A SEW32 element is wider than one lane beat and spans two adjacent lanes
// Row addresses are RowAddrW wide; register files above 32 rows need a wider field
package vlsu_pkg;

  // ----------------------------------------------------------
  // Geometry
  // ----------------------------------------------------------
  localparam int unsigned NrLanes     = 4;
  localparam int unsigned DLEN        = 16;
  localparam int unsigned NbPerLane   = DLEN / 4;
  localparam int unsigned NbPerRow    = NrLanes * NbPerLane;
  localparam int unsigned RowsPerVreg = 2;
  localparam int unsigned RowBits     = NbPerRow * 4;
  localparam int unsigned RowAddrW    = 5;
  localparam int unsigned LaneIdxW    = $clog2(NrLanes);
  localparam int unsigned NbOffW      = $clog2(NbPerLane);

  // Element width code, also the log2 of bytes per element
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  typedef struct packed {
    logic [DLEN-1:0] data;
  } lane_data_t;

  // One load request as issued by the control side
  typedef struct packed {
    logic [3:0] req_id;
    sew_e       sew;
    logic [2:0] vd;
    logic       start_row;
    logic       vm;
    logic [2:0] cmt_cnt;
  } meta_t;

  // Queued form, row address already resolved
  typedef struct packed {
    sew_e                sew;
    logic                vm;
    logic [2:0]          cmt_cnt;
    logic [RowAddrW-1:0] row_addr;
  } shf_info_t;

  // Mask bit per nibble, indexed [lane][nibble in beat]
  typedef logic [NrLanes-1:0][NbPerLane-1:0] mask_t;

  typedef struct packed {
    logic [NbPerRow-1:0][3:0] nb;
    logic [NbPerRow-1:0]      en;
    logic [RowAddrW-1:0]      row_addr;
  } seq_row_t;

  // Source of one sequential nibble in the shuffled beat
  typedef struct packed {
    logic [LaneIdxW-1:0] lane;
    logic [NbOffW-1:0]   off;
  } shf_pos_t;

  // ----------------------------------------------------------
  // Sequential nibble index to lane and offset
  // ----------------------------------------------------------
  // Element e goes to lane e mod NrLanes, elements round-robin over lanes
  // Element size capped at one lane beat so SEW32 splits into lane halves
  function automatic shf_pos_t shf_idx(input int unsigned seq, input sew_e sew);
    int unsigned n;
    int unsigned elem;
    int unsigned w;
    shf_pos_t    pos;
    n = 32'd2 << sew;
    if (n > NbPerLane) begin
      n = NbPerLane;
    end
    elem     = seq / n;
    w        = seq % n;
    pos.lane = LaneIdxW'(elem % NrLanes);
    pos.off  = NbOffW'((elem / NrLanes) * n + w);
    return pos;
  endfunction

endpackage
